/* filelist.f */
hw/mbus_pkg.sv
hw/dma_cfg_pkg.sv
hw/dma_csr.sv
hw/dma_read_engine.sv
hw/dma_fifo.sv
hw/dma_read_top.sv
tb/mem_bus_model.sv
tb/tb_dma_read.sv

/* hw/dma_cfg_pkg.sv */
package dma_cfg_pkg;

	// Register port
	localparam int CSR_ADDR_W = 4;

	// Register offsets
	localparam logic [CSR_ADDR_W-1:0] REG_START = 4'h0;
	localparam logic [CSR_ADDR_W-1:0] REG_LEN = 4'h4;
	localparam logic [CSR_ADDR_W-1:0] REG_CMD = 4'h8;

	// Commands
	localparam int CMD_W = 2;
	localparam logic [CMD_W-1:0] CMD_STOP = 2'd0;
	localparam logic [CMD_W-1:0] CMD_ONCE = 2'd1;
	localparam logic [CMD_W-1:0] CMD_AUTO = 2'd2;

	// Command register layout, low bits only
	typedef struct packed {
		logic [29:0] rsvd;
		logic [CMD_W-1:0] cmd;
	} csr_cmd_t;

	// A written word is an address/length value or a command
	typedef union packed {
		logic [31:0] value;
		csr_cmd_t ctl;
	} csr_word_u;

	// Beat FIFO
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_AW = 5;

endpackage

/* hw/dma_csr.sv */
`timescale 1ns/100ps

module dma_csr (
	input  logic frame_clk,
	input  logic frame_rst_b,
	input  logic csr_valid,
	input  logic [dma_cfg_pkg::CSR_ADDR_W-1:0] csr_addr,
	input  dma_cfg_pkg::csr_word_u csr_wdata,
	input  logic once_done,
	output logic [31:0] start_addr,
	output logic [31:0] xfer_len,
	output logic [dma_cfg_pkg::CMD_W-1:0] cmd,
	output logic cmd_written,
	output logic csr_busy_b
);

	logic wr_start;
	logic wr_len;
	logic wr_cmd;

	// Address decode
	assign wr_start = csr_valid && (csr_addr == dma_cfg_pkg::REG_START);
	assign wr_len = csr_valid && (csr_addr == dma_cfg_pkg::REG_LEN);
	assign wr_cmd = csr_valid && (csr_addr == dma_cfg_pkg::REG_CMD);

	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			start_addr <= '0;
			xfer_len <= '0;
		end else begin
			if (wr_start)
				start_addr <= csr_wdata.value;
			if (wr_len)
				xfer_len <= csr_wdata.value;
		end
	end

	// Trigger-once completion drops back to stop, a write in the same cycle wins
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			cmd <= dma_cfg_pkg::CMD_STOP;
			cmd_written <= 1'b0;
		end else begin
			cmd_written <= wr_cmd;
			if (wr_cmd)
				cmd <= csr_wdata.ctl.cmd;
			else if (once_done)
				cmd <= dma_cfg_pkg::CMD_STOP;
		end
	end

	// Write done, one cycle after any accepted write
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b)
			csr_busy_b <= 1'b0;
		else
			csr_busy_b <= csr_valid;
	end

endmodule

/* hw/dma_fifo.sv */
`timescale 1ns/100ps

module dma_fifo (
	input  logic frame_clk,
	input  logic frame_rst_b,
	input  logic beat_valid,
	input  logic [mbus_pkg::MBUS_DATA_W-1:0] beat_data,
	input  logic request,
	output logic [dma_cfg_pkg::FIFO_AW:0] fill_count,
	output logic [mbus_pkg::MBUS_DATA_W-1:0] data,
	output logic data_ready,
	output logic fifo_empty
);

	logic [mbus_pkg::MBUS_DATA_W-1:0] mem [dma_cfg_pkg::FIFO_DEPTH];
	logic [dma_cfg_pkg::FIFO_AW-1:0] wr_ptr;
	logic [dma_cfg_pkg::FIFO_AW-1:0] rd_ptr;
	logic push;
	logic pop;

	assign fifo_empty = (fill_count == '0);

	// Engine never issues a burst that would not fit
	assign push = beat_valid;
	assign pop = request && !fifo_empty;

	always_ff @(posedge frame_clk) begin
		if (push)
			mem[wr_ptr] <= beat_data;
	end

	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Push and pop together leave the count alone
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			fill_count <= '0;
		end else begin
			case ({push, pop})
				2'b10: fill_count <= fill_count + 1'b1;
				2'b01: fill_count <= fill_count - 1'b1;
				default: fill_count <= fill_count;
			endcase
		end
	end

	// User side, word appears on the edge after the request
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b)
			data_ready <= 1'b0;
		else
			data_ready <= pop;
	end

	always_ff @(posedge frame_clk) begin
		if (pop)
			data <= mem[rd_ptr];
	end

endmodule

/* hw/dma_read_engine.sv */
`timescale 1ns/100ps

module dma_read_engine (
	input  logic frame_clk,
	input  logic frame_rst_b,
	input  logic [31:0] start_addr,
	input  logic [31:0] xfer_len,
	input  logic [dma_cfg_pkg::CMD_W-1:0] cmd,
	input  logic cmd_written,
	input  logic [dma_cfg_pkg::FIFO_AW:0] fill_count,
	input  logic mbus_credit,
	input  logic mbus_rsp_valid,
	input  logic [mbus_pkg::MBUS_DID_W-1:0] mbus_rsp_did,
	input  logic [mbus_pkg::MBUS_DATA_W-1:0] mbus_rsp_data,
	output logic once_done,
	output logic mbus_req_valid,
	output logic mbus_req_mode,
	output logic [mbus_pkg::MBUS_DID_W-1:0] mbus_req_did,
	output logic [mbus_pkg::MBUS_ADDR_W-1:0] mbus_req_addr,
	output logic [mbus_pkg::MBUS_LEN_W-1:0] mbus_req_len,
	output logic beat_valid,
	output logic [mbus_pkg::MBUS_DATA_W-1:0] beat_data
);

	logic triggered;
	logic read_pending;
	logic [mbus_pkg::MBUS_ADDR_W-1:0] cur_addr;
	logic [mbus_pkg::MBUS_ADDR_W-1:0] end_addr;
	logic [2:0] beat_cnt;
	logic [mbus_pkg::MBUS_CREDIT_W-1:0] credits;
	logic credit_avail;
	logic almost_full;
	logic beat_accept;
	logic burst_last;
	logic load;

	assign credit_avail = (credits != '0);

	// Fewer than a burst worth of free slots
	assign almost_full = fill_count > (dma_cfg_pkg::FIFO_DEPTH - mbus_pkg::MBUS_BURST_BEATS);

	// Our own beats only
	assign beat_accept = mbus_rsp_valid && (mbus_rsp_did == mbus_pkg::DMA_DID);
	assign burst_last = beat_accept && read_pending && (beat_cnt == 3'd7);

	// Idle with a run command, and the last region fully retired
	assign load = !triggered && !read_pending && !once_done &&
		((cmd == dma_cfg_pkg::CMD_ONCE) || (cmd == dma_cfg_pkg::CMD_AUTO));

	assign mbus_req_valid = triggered && !read_pending && credit_avail && !almost_full;
	assign mbus_req_mode = mbus_pkg::MBUS_MODE_READ;
	assign mbus_req_did = mbus_pkg::DMA_DID;
	assign mbus_req_addr = cur_addr;
	assign mbus_req_len = mbus_pkg::MBUS_BURST_BEATS;

	assign beat_valid = beat_accept;
	assign beat_data = mbus_rsp_data;

	// Trigger FSM and address walk
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			triggered <= 1'b0;
			read_pending <= 1'b0;
			once_done <= 1'b0;
			cur_addr <= '0;
			end_addr <= '0;
		end else begin
			once_done <= 1'b0;
			if (mbus_req_valid)
				read_pending <= 1'b1;
			if (burst_last)
				read_pending <= 1'b0;
			if (burst_last && triggered) begin
				if (end_addr == cur_addr + mbus_pkg::MBUS_BURST_BYTES) begin
					triggered <= 1'b0;
					once_done <= (cmd == dma_cfg_pkg::CMD_ONCE);
				end else begin
					cur_addr <= cur_addr + mbus_pkg::MBUS_BURST_BYTES;
				end
			end
			if (load) begin
				triggered <= 1'b1;
				cur_addr <= start_addr;
				end_addr <= start_addr + xfer_len;
			end
			// New command restarts from idle
			if (cmd_written)
				triggered <= 1'b0;
		end
	end

	// Beat position within the burst
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b)
			beat_cnt <= '0;
		else if (mbus_req_valid)
			beat_cnt <= '0;
		else if (beat_accept)
			beat_cnt <= beat_cnt + 3'd1;
	end

	// Credits back from the bus, one spent per request
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			credits <= mbus_pkg::MBUS_CREDITS_INIT;
		end else begin
			case ({mbus_credit, mbus_req_valid})
				2'b10: credits <= credits + 3'd1;
				2'b01: credits <= credits - 3'd1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

/* hw/dma_read_top.sv */
`timescale 1ns/100ps

module dma_read_top (
	input  logic frame_clk,
	input  logic frame_rst_b,
	input  logic csr_valid,
	input  logic [dma_cfg_pkg::CSR_ADDR_W-1:0] csr_addr,
	input  dma_cfg_pkg::csr_word_u csr_wdata,
	output logic csr_busy_b,
	output logic mbus_req_valid,
	output logic mbus_req_mode,
	output logic [mbus_pkg::MBUS_DID_W-1:0] mbus_req_did,
	output logic [mbus_pkg::MBUS_ADDR_W-1:0] mbus_req_addr,
	output logic [mbus_pkg::MBUS_LEN_W-1:0] mbus_req_len,
	input  logic mbus_credit,
	input  logic mbus_rsp_valid,
	input  logic [mbus_pkg::MBUS_DID_W-1:0] mbus_rsp_did,
	input  logic [mbus_pkg::MBUS_DATA_W-1:0] mbus_rsp_data,
	input  logic request,
	output logic [mbus_pkg::MBUS_DATA_W-1:0] data,
	output logic data_ready,
	output logic fifo_empty
);

	logic [31:0] start_addr;
	logic [31:0] xfer_len;
	logic [dma_cfg_pkg::CMD_W-1:0] cmd;
	logic cmd_written;
	logic once_done;
	logic [dma_cfg_pkg::FIFO_AW:0] fill_count;
	logic beat_valid;
	logic [mbus_pkg::MBUS_DATA_W-1:0] beat_data;

	dma_csr csr0 (
		.frame_clk(frame_clk),
		.frame_rst_b(frame_rst_b),
		.csr_valid(csr_valid),
		.csr_addr(csr_addr),
		.csr_wdata(csr_wdata),
		.once_done(once_done),
		.start_addr(start_addr),
		.xfer_len(xfer_len),
		.cmd(cmd),
		.cmd_written(cmd_written),
		.csr_busy_b(csr_busy_b)
	);

	dma_read_engine eng0 (
		.frame_clk(frame_clk),
		.frame_rst_b(frame_rst_b),
		.start_addr(start_addr),
		.xfer_len(xfer_len),
		.cmd(cmd),
		.cmd_written(cmd_written),
		.fill_count(fill_count),
		.mbus_credit(mbus_credit),
		.mbus_rsp_valid(mbus_rsp_valid),
		.mbus_rsp_did(mbus_rsp_did),
		.mbus_rsp_data(mbus_rsp_data),
		.once_done(once_done),
		.mbus_req_valid(mbus_req_valid),
		.mbus_req_mode(mbus_req_mode),
		.mbus_req_did(mbus_req_did),
		.mbus_req_addr(mbus_req_addr),
		.mbus_req_len(mbus_req_len),
		.beat_valid(beat_valid),
		.beat_data(beat_data)
	);

	dma_fifo fifo0 (
		.frame_clk(frame_clk),
		.frame_rst_b(frame_rst_b),
		.beat_valid(beat_valid),
		.beat_data(beat_data),
		.request(request),
		.fill_count(fill_count),
		.data(data),
		.data_ready(data_ready),
		.fifo_empty(fifo_empty)
	);

endmodule

/* hw/mbus_pkg.sv */
package mbus_pkg;

	// Bus field widths
	localparam int MBUS_ADDR_W = 32;
	localparam int MBUS_DATA_W = 64;
	localparam int MBUS_LEN_W = 4;
	localparam int MBUS_DID_W = 4;

	// Request mode code for a read
	localparam logic MBUS_MODE_READ = 1'b1;

	// Credit counter
	localparam int MBUS_CREDIT_W = 3;
	localparam logic [MBUS_CREDIT_W-1:0] MBUS_CREDITS_INIT = 3'd4;

	// One burst is a 64 byte line, eight beats of 8 bytes
	localparam logic [MBUS_LEN_W-1:0] MBUS_BURST_BEATS = 4'd8;
	localparam logic [MBUS_ADDR_W-1:0] MBUS_BURST_BYTES = 32'd64;

	// Device id on the bus
	localparam logic [MBUS_DID_W-1:0] DMA_DID = 4'h3;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_dma_read -f filelist.f -o tb_dma_read \
	> build.log 2>&1 \
	&& ./obj_dir/tb_dma_read > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q -F "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

/* tb/mem_bus_model.sv */
`timescale 1ns/100ps

module mem_bus_model (
	input  logic frame_clk,
	input  logic req_valid,
	input  logic [mbus_pkg::MBUS_ADDR_W-1:0] req_addr,
	input  logic inject_foreign,
	input  int credit_lag,
	output logic credit,
	output logic rsp_valid,
	output logic [mbus_pkg::MBUS_DID_W-1:0] rsp_did,
	output logic [mbus_pkg::MBUS_DATA_W-1:0] rsp_data
);

	int unsigned lcg_state = 17529;
	int cyc;
	int credit_due[$];

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 1103515245 + 12345;
		return (lcg_state >> 16) & 32'h7fff;
	endfunction

	// One burst of eight beats after a random gap of 2 to 9 cycles
	task automatic serve(input logic [31:0] addr);
		int gap;
		logic [31:0] a;
		gap = 2 + int'(lcg_next() % 8);
		repeat (gap - 1) @(posedge frame_clk);
		if (inject_foreign) begin
			@(posedge frame_clk);
			#1;
			// Another device's beat, looks like the next line
			a = addr + 32'h40;
			rsp_valid = 1'b1;
			rsp_did = 4'h5;
			rsp_data = {a, ~a};
		end
		for (int i = 0; i < 8; i++) begin
			@(posedge frame_clk);
			#1;
			a = addr + 32'(i * 8);
			rsp_valid = 1'b1;
			rsp_did = mbus_pkg::DMA_DID;
			rsp_data = {a, ~a};
		end
		@(posedge frame_clk);
		#1;
		rsp_valid = 1'b0;
	endtask

	initial begin
		rsp_valid = 1'b0;
		rsp_did = '0;
		rsp_data = '0;
		forever begin
			@(negedge frame_clk);
			if (req_valid) begin
				credit_due.push_back(cyc + credit_lag);
				serve(req_addr);
			end
		end
	end

	// Credit return, one pulse per request after credit_lag cycles
	initial begin
		credit = 1'b0;
		cyc = 0;
		forever begin
			@(posedge frame_clk);
			#1;
			cyc++;
			credit = (credit_due.size() > 0) && (credit_due[0] <= cyc);
			if (credit)
				void'(credit_due.pop_front());
		end
	end

endmodule

/* tb/tb_dma_read.sv */
`timescale 1ns/100ps

module tb_dma_read;

	logic frame_clk;
	logic frame_rst_b;
	logic csr_valid;
	logic [dma_cfg_pkg::CSR_ADDR_W-1:0] csr_addr;
	dma_cfg_pkg::csr_word_u csr_wdata;
	logic csr_busy_b;
	logic mbus_req_valid;
	logic mbus_req_mode;
	logic [mbus_pkg::MBUS_DID_W-1:0] mbus_req_did;
	logic [mbus_pkg::MBUS_ADDR_W-1:0] mbus_req_addr;
	logic [mbus_pkg::MBUS_LEN_W-1:0] mbus_req_len;
	logic mbus_credit;
	logic mbus_rsp_valid;
	logic [mbus_pkg::MBUS_DID_W-1:0] mbus_rsp_did;
	logic [mbus_pkg::MBUS_DATA_W-1:0] mbus_rsp_data;
	logic request;
	logic [mbus_pkg::MBUS_DATA_W-1:0] data;
	logic data_ready;
	logic fifo_empty;
	logic inject_foreign;
	int credit_lag;

	// Region being read and progress through it
	logic [31:0] cur_start;
	int cur_words;
	int word_idx;
	int burst_idx;
	int req_cnt;
	int crd_cnt;
	int max_out;
	int busy_cnt;
	int wr_cnt;
	int check_cnt;
	int err_cnt;
	int test_err0;
	int base;
	bit timed_out;

	dma_read_top dut0 (.*);

	mem_bus_model mem0 (
		.frame_clk(frame_clk),
		.req_valid(mbus_req_valid),
		.req_addr(mbus_req_addr),
		.inject_foreign(inject_foreign),
		.credit_lag(credit_lag),
		.credit(mbus_credit),
		.rsp_valid(mbus_rsp_valid),
		.rsp_did(mbus_rsp_did),
		.rsp_data(mbus_rsp_data)
	);

	always #4 frame_clk = ~frame_clk;

	// Beat at byte address A is {A, ~A}
	function automatic logic [63:0] ref_beat(input logic [31:0] start, input int idx);
		logic [31:0] a;
		a = start + 32'(idx * 8);
		return {a, ~a};
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic csr_write(input logic [3:0] addr, input logic [31:0] value);
		@(posedge frame_clk);
		#1;
		csr_valid = 1'b1;
		csr_addr = addr;
		csr_wdata = value;
		@(posedge frame_clk);
		#1;
		csr_valid = 1'b0;
		wr_cnt++;
	endtask

	task automatic start_region(input logic [31:0] start, input int len, input logic [1:0] cmd);
		cur_start = start;
		cur_words = len / 8;
		word_idx = 0;
		burst_idx = 0;
		csr_write(dma_cfg_pkg::REG_START, start);
		csr_write(dma_cfg_pkg::REG_LEN, 32'(len));
		csr_write(dma_cfg_pkg::REG_CMD, {30'd0, cmd});
	endtask

	task automatic wait_words(input int target, input int limit);
		int n;
		n = 0;
		while (word_idx < target && n < limit && !timed_out) begin
			@(posedge frame_clk);
			#1;
			n++;
		end
		if (word_idx < target && !timed_out) begin
			$display("Timeout: only %0d of %0d words arrived at %0t", word_idx, target, $time);
			timed_out = 1'b1;
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge frame_clk);
			#1;
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %s", num, name,
			(err_cnt == test_err0 && !timed_out) ? "ok" : "failed");
		test_err0 = err_cnt;
	endtask

	// Compare every user word and count requests, credits and busy pulses
	always @(negedge frame_clk) begin
		if (mbus_req_valid) begin
			req_cnt++;
			check_val("mbus_req_len", 64'(mbus_req_len), 64'(mbus_pkg::MBUS_BURST_BEATS));
			check_val("mbus_req_did", 64'(mbus_req_did), 64'(mbus_pkg::DMA_DID));
			check_val("mbus_req_mode", 64'(mbus_req_mode), 64'(mbus_pkg::MBUS_MODE_READ));
			// Bursts walk the region in 64 byte steps and wrap on autotrigger
			check_val("mbus_req_addr", 64'(mbus_req_addr),
				64'(cur_start + 32'((burst_idx % (cur_words / 8)) * 64)));
			burst_idx++;
		end
		if (mbus_credit)
			crd_cnt++;
		if (req_cnt - crd_cnt > max_out)
			max_out = req_cnt - crd_cnt;
		if (csr_busy_b)
			busy_cnt++;
		if (data_ready) begin
			check_val("data", data, ref_beat(cur_start, word_idx % cur_words));
			word_idx++;
		end
	end

	initial begin
		frame_clk = 1'b0;
		frame_rst_b = 1'b0;
		csr_valid = 1'b0;
		csr_addr = '0;
		csr_wdata = '0;
		request = 1'b0;
		inject_foreign = 1'b0;
		credit_lag = 3;
		cur_start = '0;
		cur_words = 1;
		timed_out = 1'b0;
		repeat (8) @(posedge frame_clk);
		#1;
		frame_rst_b = 1'b1;

		request = 1'b1;
		start_region(32'h1000, 256, dma_cfg_pkg::CMD_ONCE);
		wait_words(32, 2000);
		check_val("fifo_empty", 64'(fifo_empty), 64'd1);
		base = req_cnt;
		idle_cycles(200);
		check_val("mbus_req_valid after done", 64'(req_cnt - base), 64'd0);
		end_test(1, "trigger once");

		// No user reads so the FIFO fills up
		request = 1'b0;
		base = req_cnt;
		start_region(32'h2000, 512, dma_cfg_pkg::CMD_ONCE);
		idle_cycles(300);
		check_val("burst words over depth", 64'((req_cnt - base) * 8 > dma_cfg_pkg::FIFO_DEPTH),
			64'd0);
		request = 1'b1;
		wait_words(64, 3000);
		end_test(2, "back-pressure");

		start_region(32'h3000, 128, dma_cfg_pkg::CMD_AUTO);
		wait_words(48, 4000);
		csr_write(dma_cfg_pkg::REG_CMD, {30'd0, dma_cfg_pkg::CMD_STOP});
		base = req_cnt;
		idle_cycles(200);
		check_val("bursts after stop over one", 64'(req_cnt - base > 1), 64'd0);
		check_val("partial burst words", 64'(word_idx % 8), 64'd0);
		end_test(3, "autotrigger and stop");

		inject_foreign = 1'b1;
		start_region(32'h4000, 256, dma_cfg_pkg::CMD_ONCE);
		wait_words(32, 3000);
		idle_cycles(50);
		check_val("word count", 64'(word_idx), 64'd32);
		inject_foreign = 1'b0;
		end_test(4, "foreign beats");

		// Slow credits make the controller stall on its own count
		credit_lag = 100;
		start_region(32'h5000, 512, dma_cfg_pkg::CMD_ONCE);
		wait_words(64, 3000);
		check_val("outstanding over credits", 64'(max_out > int'(mbus_pkg::MBUS_CREDITS_INIT)),
			64'd0);
		check_val("csr_busy_b pulses", 64'(busy_cnt), 64'(wr_cnt));
		end_test(5, "credits and busy");

		$display("5 tests, %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
